//--- flist.f
+incdir+tb
verilog/l2e_pkg.sv
verilog/cfg_regs.sv
verilog/tile_mem.sv
verilog/mem_cmd_router.sv
verilog/l2e_tile.sv
tb/tb_l2e_tile.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it.
# The exit status is nonzero when the build or the simulation fails.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_l2e_tile -f flist.f -o tb_l2e_tile
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/tb_l2e_tile
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

echo "Simulation finished with status 0"
exit 0

//--- tb/tb_vectors.svh
//////////////////////////////////////////////////////////////
// Directed vectors, applied in order. Reads expect the data
// left by earlier entries; write responses carry zero data.
//////////////////////////////////////////////////////////////

`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns: opcode, address, write data, expected read data
typedef struct packed {
  mem_op_e     op;
  logic [31:0] addr;
  logic [31:0] wdata;
  logic [31:0] rdata;
} vec_t;

// Expected data of a write entry
localparam logic [31:0] wr_mark = 32'h0;
localparam int unsigned n_vecs  = 25;

vec_t vecs [n_vecs];

task automatic load_vectors();
  // Tile memory in both regions, 8000_0408 aliases word 2
  vecs[0]  = '{op_wr, 32'h8000_0000, 32'h1111_0001, wr_mark};
  vecs[1]  = '{op_wr, 32'h8000_0004, 32'h2222_0002, wr_mark};
  vecs[2]  = '{op_wr, 32'h0020_0008, 32'h3333_0003, wr_mark};
  vecs[3]  = '{op_wr, 32'h0020_03fc, 32'h4444_00ff, wr_mark};
  vecs[4]  = '{op_rd, 32'h8000_0000, 32'h0, 32'h1111_0001};
  vecs[5]  = '{op_rd, 32'h8000_0004, 32'h0, 32'h2222_0002};
  vecs[6]  = '{op_rd, 32'h0020_0008, 32'h0, 32'h3333_0003};
  vecs[7]  = '{op_rd, 32'h0020_03fc, 32'h0, 32'h4444_00ff};
  vecs[8]  = '{op_rd, 32'h8000_0408, 32'h0, 32'h3333_0003};
  // Config block, register 0 is the device id
  vecs[9]  = '{op_rd, 32'h0010_0000, 32'h0, 32'h0000_005a};
  vecs[10] = '{op_wr, 32'h0010_0000, 32'hdead_beef, wr_mark};
  vecs[11] = '{op_rd, 32'h0010_0000, 32'h0, 32'h0000_005a};
  vecs[12] = '{op_rd, 32'h0010_0004, 32'h0, 32'h0};
  vecs[13] = '{op_rd, 32'h0010_001c, 32'h0, 32'h0};
  vecs[14] = '{op_wr, 32'h0010_0004, 32'ha5a5_0001, wr_mark};
  vecs[15] = '{op_wr, 32'h0010_001c, 32'hc3c3_0007, wr_mark};
  vecs[16] = '{op_rd, 32'h0010_0004, 32'h0, 32'ha5a5_0001};
  vecs[17] = '{op_rd, 32'h0010_001c, 32'h0, 32'hc3c3_0007};
  // Loopback on devices 3, 0 and 15
  vecs[18] = '{op_wr, 32'h0030_0004, 32'hffff_ffff, wr_mark};
  vecs[19] = '{op_rd, 32'h0030_0004, 32'h0, 32'h0};
  vecs[20] = '{op_wr, 32'h0000_0008, 32'h1234_5678, wr_mark};
  vecs[21] = '{op_rd, 32'h0000_0008, 32'h0, 32'h0};
  // Word 2 and config register 2 untouched by the loopback writes
  vecs[22] = '{op_rd, 32'h8000_0008, 32'h0, 32'h3333_0003};
  vecs[23] = '{op_rd, 32'h0010_0008, 32'h0, 32'h0};
  vecs[24] = '{op_rd, 32'h7ff0_0000, 32'h0, 32'h0};
endtask

`endif

//--- tb/tb_l2e_tile.sv
//////////////////////////////////////////////////////////////
// Inputs change on falling edges, outputs are sampled 1 ns
// later. The run stops at the first error.
//////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_l2e_tile;
  import l2e_pkg::*;

  `include "tb_vectors.svh"

  localparam int unsigned mem_words = 256;
  localparam int unsigned idx_w     = $clog2(mem_words);
  localparam int unsigned n_rand    = 200;
  localparam int unsigned wd_cycles = (n_vecs + n_rand + mem_words + 16) * 200;
  localparam logic [did_w-1:0] test_did = 8'h5a;

  logic             clk_i = 1'b0;
  logic             rst_n_i;
  logic [did_w-1:0] did_i;
  logic             cmd_valid_i;
  mem_cmd_t         cmd_i;
  logic             cmd_ready_o;
  logic             resp_valid_o;
  mem_resp_t        resp_o;
  logic             resp_ready_i;

  logic [31:0] lcg_state = 32'h027d_cb92;
  logic [31:0] model_mem [mem_words];

  l2e_tile #(.mem_words_p(mem_words)) DUT (.*);

  always #5 clk_i = ~clk_i;

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("Test failures found");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Halves swapped, low LCG bits have short periods
  task automatic draw(output logic [31:0] r);
    lcg_state = lcg_next(lcg_state);
    r = {lcg_state[15:0], lcg_state[31:16]};
  endtask

  // Starts and returns at a falling edge
  task automatic send_cmd(input mem_op_e op, input logic [31:0] addr,
                          input logic [31:0] data);
    cmd_valid_i = 1'b1;
    cmd_i       = '{op, addr, data};
    #1;
    while (!cmd_ready_o) begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    cmd_valid_i = 1'b0;
  endtask

  task automatic recv_resp(input logic rand_rdy, output mem_resp_t got,
                           output int waited);
    logic [31:0] r;
    logic        done;
    waited = 0;
    done   = 1'b0;
    while (!done) begin
      draw(r);
      resp_ready_i = rand_rdy ? r[3] : 1'b1;
      #1;
      done = resp_valid_o & resp_ready_i;
      if (!done) begin
        waited++;
        @(negedge clk_i);
      end
    end
    got = resp_o;
    @(negedge clk_i);
  endtask

  task automatic check_resp(input mem_resp_t got, input mem_op_e op,
                            input logic [31:0] addr, input logic [31:0] data);
    check_value("response opcode", 32'(got.op), 32'(op));
    check_value("response address", got.addr, addr);
    check_value("response data", got.data, data);
  endtask

  task automatic transact(input mem_op_e op, input logic [31:0] addr,
                          input logic [31:0] data, input logic [31:0] exp,
                          input logic rand_rdy);
    mem_resp_t got;
    int        waited;
    send_cmd(op, addr, data);
    recv_resp(rand_rdy, got, waited);
    if (!rand_rdy) check_value("response wait cycles", 32'(waited), 32'd0);
    check_resp(got, op, addr, exp);
  endtask

  initial begin
    mem_resp_t   got;
    int          waited;
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] exp;
    mem_op_e     op;

    rst_n_i      = 1'b0;
    did_i        = test_did;
    cmd_valid_i  = 1'b0;
    cmd_i        = '0;
    resp_ready_i = 1'b0;
    load_vectors();
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    #1;
    check_value("cmd_ready_o after reset", 32'(cmd_ready_o), 32'd1);
    check_value("resp_valid_o after reset", 32'(resp_valid_o), 32'd0);
    @(negedge clk_i);

    for (int i = 0; i < n_vecs; i++) begin
      transact(vecs[i].op, vecs[i].addr, vecs[i].wdata, vecs[i].rdata, 1'b0);
    end

    // One response held per target, then a stalled memory command
    resp_ready_i = 1'b0;
    send_cmd(op_rd, 32'h0040_0000, 32'h0);
    send_cmd(op_rd, 32'h0010_0004, 32'h0);
    send_cmd(op_rd, 32'h8000_0004, 32'h0);
    cmd_valid_i = 1'b1;
    cmd_i       = '{op_wr, 32'h8000_0010, 32'h4444_0004};
    repeat (4) begin
      #1;
      check_value("cmd_ready_o while memory holds", 32'(cmd_ready_o), 32'd0);
      check_value("resp_valid_o while stalled", 32'(resp_valid_o), 32'd1);
      check_value("granted address", resp_o.addr, 32'h8000_0004);
      @(negedge clk_i);
    end
    cmd_valid_i = 1'b0;
    recv_resp(1'b0, got, waited);
    check_resp(got, op_rd, 32'h8000_0004, 32'h2222_0002);
    recv_resp(1'b0, got, waited);
    check_resp(got, op_rd, 32'h0010_0004, 32'ha5a5_0001);
    recv_resp(1'b0, got, waited);
    check_resp(got, op_rd, 32'h0040_0000, 32'h0);
    transact(op_wr, 32'h8000_0010, 32'h4444_0004, 32'h0, 1'b0);
    transact(op_rd, 32'h8000_0010, 32'h0, 32'h4444_0004, 1'b0);

    // Fill every word so random reads never see undefined data
    for (int i = 0; i < mem_words; i++) begin
      a = dram_base | (32'(i) << 2);
      d = {~a[15:0], a[15:0]} ^ 32'h3c5a_0000;
      model_mem[i] = d;
      transact(op_wr, a, d, 32'h0, 1'b0);
    end

    for (int i = 0; i < n_rand; i++) begin
      draw(r);
      draw(d);
      a = (r[1] ? dram_base : 32'h0020_0000) | {18'd0, r[13:2], 2'b00};
      if (r[0]) begin
        op  = op_wr;
        exp = 32'h0;
        model_mem[a[2 +: idx_w]] = d;
      end else begin
        op  = op_rd;
        exp = model_mem[a[2 +: idx_w]];
      end
      transact(op, a, d, exp, 1'b1);
    end

    $display("All tests passed!");
    $finish;
  end

  initial begin
    repeat (wd_cycles) @(posedge clk_i);
    $display("Test failures found");
    $display("Timeout: the run did not finish within %0d clock cycles", wd_cycles);
    $fatal(1, "watchdog expired");
  end

endmodule

//--- verilog/cfg_regs.sv
//////////////////////////////////////////////////////////////
// Eight config registers at address bits 4:2.
// Register 0 is the read-only device id.
//////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cfg_regs (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic [l2e_pkg::did_w-1:0]  did_i,
  input  logic                       cmd_valid_i,
  input  l2e_pkg::mem_cmd_t          cmd_i,
  output logic                       cmd_ready_o,
  output logic                       resp_valid_o,
  output l2e_pkg::mem_resp_t         resp_o,
  input  logic                       resp_ready_i
);
  import l2e_pkg::*;

  logic [2:0]        idx;
  logic [data_w-1:0] regs_q [1:7];
  logic [data_w-1:0] rd_data;
  logic              accept;
  logic              is_wr;
  logic              resp_valid_q;
  mem_resp_t         resp_q;

  assign idx         = cmd_i.addr[4:2];
  assign is_wr       = (cmd_i.op == op_wr);
  assign cmd_ready_o = ~resp_valid_q;
  assign accept      = cmd_valid_i & cmd_ready_o;

  always_comb begin
    if (idx == 3'd0) begin
      rd_data = {{(data_w - did_w){1'b0}}, did_i};
    end else begin
      rd_data = regs_q[idx];
    end
  end

  // Writes to register 0 are dropped
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 8; i++) begin
        regs_q[i] <= '0;
      end
    end else if (accept && is_wr && idx != 3'd0) begin
      regs_q[idx] <= cmd_i.data;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_valid_q <= 1'b0;
    end else if (accept) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      resp_q.op   <= cmd_i.op;
      resp_q.addr <= cmd_i.addr;
      resp_q.data <= is_wr ? '0 : rd_data;
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_o       = resp_q;

endmodule

//--- verilog/l2e_pkg.sv
//////////////////////////////////////////////////////////////
// Address map, widths and message types of the tile fabric.
// Local space is everything below dram_base, split by device.
//////////////////////////////////////////////////////////////

package l2e_pkg;

  localparam int unsigned addr_w = 32;
  localparam int unsigned data_w = 32;

  // Memory map
  localparam logic [addr_w-1:0] dram_base = 32'h8000_0000;
  localparam int unsigned       dev_lsb   = 20;
  localparam int unsigned       dev_w     = 4;

  localparam logic [dev_w-1:0] cfg_dev = 4'd1;
  localparam logic [dev_w-1:0] mem_dev = 4'd2;

  // Width of the device id read back from config register 0
  localparam int unsigned did_w = 8;

  typedef enum logic [0:0] {
    op_rd = 1'b0,
    op_wr = 1'b1
  } mem_op_e;

  typedef struct packed {
    mem_op_e           op;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
  } mem_cmd_t;

  // Opcode and address echo the command, data is zero for writes
  typedef struct packed {
    mem_op_e           op;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
  } mem_resp_t;

  // Decode targets, listed in response priority order
  typedef enum logic [1:0] {
    tgt_mem  = 2'd0,
    tgt_cfg  = 2'd1,
    tgt_loop = 2'd2
  } target_e;

endpackage

//--- verilog/l2e_tile.sv
//////////////////////////////////////////////////////////////
// Memory-side command fabric of one tile.
// mem_words_p must be a power of two, at least 2.
//////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module l2e_tile #(
  parameter int unsigned mem_words_p = 256
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic [l2e_pkg::did_w-1:0]  did_i,
  input  logic                       cmd_valid_i,
  input  l2e_pkg::mem_cmd_t          cmd_i,
  output logic                       cmd_ready_o,
  output logic                       resp_valid_o,
  output l2e_pkg::mem_resp_t         resp_o,
  input  logic                       resp_ready_i
);
  import l2e_pkg::*;

  mem_cmd_t  tgt_cmd;
  logic      mem_cmd_valid;
  logic      mem_cmd_ready;
  logic      mem_resp_valid;
  mem_resp_t mem_resp;
  logic      mem_resp_ready;
  logic      cfg_cmd_valid;
  logic      cfg_cmd_ready;
  logic      cfg_resp_valid;
  mem_resp_t cfg_resp;
  logic      cfg_resp_ready;

  mem_cmd_router u_router (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .cmd_valid_i      (cmd_valid_i),
    .cmd_i            (cmd_i),
    .cmd_ready_o      (cmd_ready_o),
    .resp_valid_o     (resp_valid_o),
    .resp_o           (resp_o),
    .resp_ready_i     (resp_ready_i),
    .tgt_cmd_o        (tgt_cmd),
    .mem_cmd_valid_o  (mem_cmd_valid),
    .mem_cmd_ready_i  (mem_cmd_ready),
    .mem_resp_valid_i (mem_resp_valid),
    .mem_resp_i       (mem_resp),
    .mem_resp_ready_o (mem_resp_ready),
    .cfg_cmd_valid_o  (cfg_cmd_valid),
    .cfg_cmd_ready_i  (cfg_cmd_ready),
    .cfg_resp_valid_i (cfg_resp_valid),
    .cfg_resp_i       (cfg_resp),
    .cfg_resp_ready_o (cfg_resp_ready)
  );

  cfg_regs u_cfg (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .did_i        (did_i),
    .cmd_valid_i  (cfg_cmd_valid),
    .cmd_i        (tgt_cmd),
    .cmd_ready_o  (cfg_cmd_ready),
    .resp_valid_o (cfg_resp_valid),
    .resp_o       (cfg_resp),
    .resp_ready_i (cfg_resp_ready)
  );

  tile_mem #(
    .mem_words_p (mem_words_p)
  ) u_mem (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .cmd_valid_i  (mem_cmd_valid),
    .cmd_i        (tgt_cmd),
    .cmd_ready_o  (mem_cmd_ready),
    .resp_valid_o (mem_resp_valid),
    .resp_o       (mem_resp),
    .resp_ready_i (mem_resp_ready)
  );

endmodule

//--- verilog/mem_cmd_router.sv
//////////////////////////////////////////////////////////////
// Routes commands to memory, config or loopback by address.
// One response per target in flight, fixed priority merge.
//////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mem_cmd_router (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               cmd_valid_i,
  input  l2e_pkg::mem_cmd_t  cmd_i,
  output logic               cmd_ready_o,
  output logic               resp_valid_o,
  output l2e_pkg::mem_resp_t resp_o,
  input  logic               resp_ready_i,
  output l2e_pkg::mem_cmd_t  tgt_cmd_o,
  output logic               mem_cmd_valid_o,
  input  logic               mem_cmd_ready_i,
  input  logic               mem_resp_valid_i,
  input  l2e_pkg::mem_resp_t mem_resp_i,
  output logic               mem_resp_ready_o,
  output logic               cfg_cmd_valid_o,
  input  logic               cfg_cmd_ready_i,
  input  logic               cfg_resp_valid_i,
  input  l2e_pkg::mem_resp_t cfg_resp_i,
  output logic               cfg_resp_ready_o
);
  import l2e_pkg::*;

  target_e          tgt;
  logic [dev_w-1:0] dev;
  logic             loop_cmd_valid;
  logic             loop_cmd_ready;
  logic             loop_resp_valid_q;
  mem_resp_t        loop_resp_q;
  logic             gnt_mem;
  logic             gnt_cfg;
  logic             gnt_loop;

  assign dev = cmd_i.addr[dev_lsb +: dev_w];

  // Address decode
  always_comb begin
    if (cmd_i.addr >= dram_base) begin
      tgt = tgt_mem;
    end else if (dev == cfg_dev) begin
      tgt = tgt_cfg;
    end else if (dev == mem_dev) begin
      tgt = tgt_mem;
    end else begin
      tgt = tgt_loop;
    end
  end

  // All targets see the same command bus, only one gets valid
  assign tgt_cmd_o       = cmd_i;
  assign mem_cmd_valid_o = cmd_valid_i & (tgt == tgt_mem);
  assign cfg_cmd_valid_o = cmd_valid_i & (tgt == tgt_cfg);
  assign loop_cmd_valid  = cmd_valid_i & (tgt == tgt_loop);

  // Ready follows the decoded target so each target can hold one response
  always_comb begin
    case (tgt)
      tgt_mem:  cmd_ready_o = mem_cmd_ready_i;
      tgt_cfg:  cmd_ready_o = cfg_cmd_ready_i;
      default:  cmd_ready_o = loop_cmd_ready;
    endcase
  end

  // Loopback responder for unmapped local devices
  assign loop_cmd_ready = ~loop_resp_valid_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      loop_resp_valid_q <= 1'b0;
    end else if (loop_cmd_valid && loop_cmd_ready) begin
      loop_resp_valid_q <= 1'b1;
    end else if (gnt_loop && resp_ready_i) begin
      loop_resp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (loop_cmd_valid && loop_cmd_ready) begin
      loop_resp_q.op   <= cmd_i.op;
      loop_resp_q.addr <= cmd_i.addr;
      loop_resp_q.data <= '0;
    end
  end

  // Fixed priority: memory, then config, then loopback
  assign gnt_mem  = mem_resp_valid_i;
  assign gnt_cfg  = cfg_resp_valid_i & ~mem_resp_valid_i;
  assign gnt_loop = loop_resp_valid_q & ~mem_resp_valid_i & ~cfg_resp_valid_i;

  assign resp_valid_o = mem_resp_valid_i | cfg_resp_valid_i | loop_resp_valid_q;

  always_comb begin
    if (gnt_mem) begin
      resp_o = mem_resp_i;
    end else if (gnt_cfg) begin
      resp_o = cfg_resp_i;
    end else begin
      resp_o = loop_resp_q;
    end
  end

  assign mem_resp_ready_o = resp_ready_i & gnt_mem;
  assign cfg_resp_ready_o = resp_ready_i & gnt_cfg;

endmodule

//--- verilog/tile_mem.sv
//////////////////////////////////////////////////////////////
// Direct word store, never misses. Addresses alias modulo
// mem_words_p words. Contents are undefined after reset.
//////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tile_mem #(
  parameter int unsigned mem_words_p = 256
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               cmd_valid_i,
  input  l2e_pkg::mem_cmd_t  cmd_i,
  output logic               cmd_ready_o,
  output logic               resp_valid_o,
  output l2e_pkg::mem_resp_t resp_o,
  input  logic               resp_ready_i
);
  import l2e_pkg::*;

  localparam int unsigned idx_w = $clog2(mem_words_p);

  logic [data_w-1:0] mem_q [mem_words_p];
  logic [idx_w-1:0]  idx;
  logic              accept;
  logic              is_wr;
  logic              resp_valid_q;
  mem_resp_t         resp_q;

  // Word index, byte offset dropped
  assign idx         = cmd_i.addr[2 +: idx_w];
  assign is_wr       = (cmd_i.op == op_wr);
  assign cmd_ready_o = ~resp_valid_q;
  assign accept      = cmd_valid_i & cmd_ready_o;

  always_ff @(posedge clk_i) begin
    if (accept && is_wr) begin
      mem_q[idx] <= cmd_i.data;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_valid_q <= 1'b0;
    end else if (accept) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  // Read data is the word as it was before this edge
  always_ff @(posedge clk_i) begin
    if (accept) begin
      resp_q.op   <= cmd_i.op;
      resp_q.addr <= cmd_i.addr;
      resp_q.data <= is_wr ? '0 : mem_q[idx];
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_o       = resp_q;

endmodule
